/* list.f */
common/panel_pkg.sv
common/fb_write_if.sv
control/control_subcmd_fillarea.sv
control/control_cmd_fillpanel.sv
control/control_cmd_fillrect.sv
control/control_cmd_dispatch.sv
hdl/framebuffer.sv
hdl/panel_ctrl_top.sv
verif/clk_gen.sv
verif/panel_ctrl_tb.sv

/* Makefile */
TOP = panel_ctrl_tb

all: run

run:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) --Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* verif/panel_ctrl_tb.sv */
//////////////////////////////
// Frame memory is not reset, so the first entry clears the panel to black
//////////////////////////////
`timescale 1ns/1ps

module panel_ctrl_tb;

    localparam int NUM_TESTS = 7;
    localparam int MAX_BYTES = 8;
    localparam int W = panel_pkg::PANEL_WIDTH;
    localparam int H = panel_pkg::PANEL_HEIGHT;

    logic clk;
    logic reset;
    logic [7:0] data_in;
    logic data_valid;
    logic ready;
    logic cmd_done;
    panel_pkg::row_t rd_row;
    panel_pkg::col_t rd_column;
    panel_pkg::pix_t rd_pixel;
    logic [7:0] rd_data;

    // The stimulus table uses -1 in exp_cycles where no cmd_done may appear
    string test_name [NUM_TESTS];
    logic [7:0] cmd_bytes [NUM_TESTS][MAX_BYTES];
    int cmd_len [NUM_TESTS];
    int exp_cycles [NUM_TESTS];

    logic [7:0] model [panel_pkg::FB_BYTES];
    logic [31:0] rng;
    bit table_built;
    int cycle = 0;
    int done_count = 0;
    int accept_cycle;
    int errors = 0;
    int tests_failed = 0;

    clk_gen i_clk_gen (
        .clk(clk),
        .reset(reset)
    );

    panel_ctrl_top i_panel_ctrl_top (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .ready(ready),
        .cmd_done(cmd_done),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cmd_done) begin
            done_count <= done_count + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    task automatic draw(input int range, output int value);
        rng = xorshift32(rng);
        value = int'(rng % 32'(range));
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_color(input string name, input panel_pkg::color_t exp,
                               input panel_pkg::color_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %06h actual %06h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    //////////////////////////////
    // Table and reference model
    //////////////////////////////
    task automatic add_panel(input int t, input string name, input panel_pkg::color_t color);
        test_name[t] = name;
        cmd_bytes[t][0] = panel_pkg::OP_FILL_PANEL;
        cmd_bytes[t][1] = color[23:16];
        cmd_bytes[t][2] = color[15:8];
        cmd_bytes[t][3] = color[7:0];
        cmd_len[t] = 1 + panel_pkg::FILLPANEL_ARG_BYTES;
        exp_cycles[t] = W * H * panel_pkg::BYTES_PER_PIXEL + 4;
    endtask

    task automatic add_rect(input int t, input string name, input int x1, input int y1,
                            input int w, input int h, input panel_pkg::color_t color);
        test_name[t] = name;
        cmd_bytes[t][0] = panel_pkg::OP_FILL_RECT;
        cmd_bytes[t][1] = 8'(x1);
        cmd_bytes[t][2] = 8'(y1);
        cmd_bytes[t][3] = 8'(w);
        cmd_bytes[t][4] = 8'(h);
        cmd_bytes[t][5] = color[23:16];
        cmd_bytes[t][6] = color[15:8];
        cmd_bytes[t][7] = color[7:0];
        cmd_len[t] = 1 + panel_pkg::FILLRECT_ARG_BYTES;
        exp_cycles[t] = w * h * panel_pkg::BYTES_PER_PIXEL + 4;
    endtask

    task automatic build_table();
        int x1;
        int y1;
        int w;
        int h;
        add_panel(0, "clear_black", 24'h000000);
        rng = xorshift32(rng);
        add_panel(1, "fill_panel_random", rng[23:0]);
        // Kept clear of the edges so every neighbour is on the panel
        draw(40, x1);
        draw(14, y1);
        draw(20, w);
        draw(14, h);
        rng = xorshift32(rng);
        add_rect(2, "rect_inside", x1 + 1, y1 + 1, w + 1, h + 1, rng[23:0]);
        draw(6, x1);
        draw(4, y1);
        draw(8, w);
        draw(4, h);
        rng = xorshift32(rng);
        add_rect(3, "rect_clipped", x1 + 56, y1 + 26, w + 8, h + 6, rng[23:0]);
        test_name[4] = "unknown_opcode";
        cmd_bytes[4][0] = 8'h7e;
        cmd_len[4] = 1;
        exp_cycles[4] = -1;
        draw(60, x1);
        draw(28, y1);
        draw(8, w);
        draw(6, h);
        rng = xorshift32(rng);
        add_rect(5, "rect_after_unknown", x1, y1, w + 1, h + 1, rng[23:0]);
        rng = xorshift32(rng);
        add_rect(6, "zero_width", 5, 5, 0, 7, rng[23:0]);
    endtask

    task automatic apply_model(input int t);
        int x1;
        int y1;
        int w;
        int h;
        int r;
        int c;
        int idx;
        panel_pkg::color_t color;
        x1 = 0;
        y1 = 0;
        w = 0;
        h = 0;
        color = '0;
        if (cmd_bytes[t][0] == panel_pkg::OP_FILL_PANEL) begin
            w = W;
            h = H;
            color = {cmd_bytes[t][1], cmd_bytes[t][2], cmd_bytes[t][3]};
        end else if (cmd_bytes[t][0] == panel_pkg::OP_FILL_RECT) begin
            x1 = int'(cmd_bytes[t][1]);
            y1 = int'(cmd_bytes[t][2]);
            w = int'(cmd_bytes[t][3]);
            h = int'(cmd_bytes[t][4]);
            color = {cmd_bytes[t][5], cmd_bytes[t][6], cmd_bytes[t][7]};
        end
        for (r = 0; r < h; r++) begin
            for (c = 0; c < w; c++) begin
                if (x1 + c < W && y1 + r < H) begin
                    idx = ((y1 + r) * W + x1 + c) * 3;
                    model[idx + 2] = color[23:16];
                    model[idx + 1] = color[15:8];
                    model[idx] = color[7:0];
                end
            end
        end
    endtask

    //////////////////////////////
    // Host side
    //////////////////////////////
    task automatic send_byte(input logic [7:0] value);
        data_in = value;
        data_valid = 1'b1;
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        data_valid = 1'b0;
        accept_cycle = cycle;
    endtask

    task automatic read_byte(input int row, input int col, input int pix,
                             output logic [7:0] value);
        rd_row = panel_pkg::row_t'(row);
        rd_column = panel_pkg::col_t'(col);
        rd_pixel = panel_pkg::pix_t'(pix);
        @(posedge clk);
        #1;
        value = rd_data;
    endtask

    task automatic probe_color(input int t, input int row, input int col);
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;
        int idx;
        if (row < 0 || row >= H || col < 0 || col >= W) begin
            return;
        end
        read_byte(row, col, 2, b2);
        read_byte(row, col, 1, b1);
        read_byte(row, col, 0, b0);
        idx = (row * W + col) * 3;
        check_color($sformatf("%s pixel (%0d,%0d)", test_name[t], col, row),
                    {model[idx + 2], model[idx + 1], model[idx]}, {b2, b1, b0});
    endtask

    task automatic probe_test(input int t);
        int k;
        int r;
        int c;
        int p;
        int x1;
        int y1;
        int w;
        int h;
        logic [7:0] value;
        probe_color(t, 0, 0);
        probe_color(t, 0, W - 1);
        probe_color(t, H - 1, 0);
        probe_color(t, H - 1, W - 1);
        probe_color(t, H / 2, W / 2);
        for (k = 0; k < 6; k++) begin
            draw(H, r);
            draw(W, c);
            draw(3, p);
            read_byte(r, c, p, value);
            check_byte($sformatf("%s byte (%0d,%0d,%0d)", test_name[t], c, r, p),
                       model[(r * W + c) * 3 + p], value);
        end
        if (cmd_bytes[t][0] == panel_pkg::OP_FILL_RECT) begin
            x1 = int'(cmd_bytes[t][1]);
            y1 = int'(cmd_bytes[t][2]);
            w = int'(cmd_bytes[t][3]);
            h = int'(cmd_bytes[t][4]);
            probe_color(t, y1, x1);
            probe_color(t, y1 + h - 1, x1 + w - 1);
            probe_color(t, y1, x1 - 1);
            probe_color(t, y1, x1 + w);
            probe_color(t, y1 - 1, x1);
            probe_color(t, y1 + h, x1);
            // Where an unclipped walk would wrap back onto the panel
            probe_color(t, y1, x1 + w - 1 - W);
            probe_color(t, y1 + h - 1 - H, x1);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors > errs_before) begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int done_before;
        int i;
        errs_before = errors;
        done_before = done_count;
        for (i = 0; i < cmd_len[t]; i++) begin
            send_byte(cmd_bytes[t][i]);
        end
        apply_model(t);
        if (exp_cycles[t] >= 0) begin
            check_flag({test_name[t], " ready during fill"}, 1'b0, ready);
            while (cmd_done !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            check_cycles({test_name[t], " latency"}, exp_cycles[t], cycle - accept_cycle);
            check_flag({test_name[t], " ready at done"}, 1'b1, ready);
            repeat (3) begin
                @(posedge clk);
                #1;
            end
            check_cycles({test_name[t], " done pulses"}, 1, done_count - done_before);
        end else begin
            check_flag({test_name[t], " ready"}, 1'b1, ready);
            repeat (20) begin
                @(posedge clk);
                #1;
            end
            check_cycles({test_name[t], " done pulses"}, 0, done_count - done_before);
        end
        probe_test(t);
        finish_test(test_name[t], errs_before);
    endtask

    initial begin
        int t;
        data_in = 8'h00;
        data_valid = 1'b0;
        rd_row = '0;
        rd_column = '0;
        rd_pixel = '0;
        rng = 32'ha466_f8b4;
        build_table();
        table_built = 1'b1;
        wait (reset === 1'b0);
        @(posedge clk);
        #1;
        check_flag("reset_state ready", 1'b1, ready);
        check_flag("reset_state cmd_done", 1'b0, cmd_done);
        repeat (20) begin
            @(posedge clk);
            #1;
        end
        check_cycles("reset_state done pulses", 0, done_count);
        finish_test("reset_state", 0);
        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS + 1, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Limit is the sum of all expected fill latencies plus slack for bytes and probes
    initial begin
        int limit;
        int t;
        wait (table_built);
        limit = 2000;
        for (t = 0; t < NUM_TESTS; t++) begin
            if (exp_cycles[t] > 0) begin
                limit += exp_cycles[t];
            end
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verif/clk_gen.sv */
//////////////////////////////
// 10 ns clock. Reset is held for 10 rising edges
//////////////////////////////
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Released just after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* hdl/panel_ctrl_top.sv */
//////////////////////////////
// Single clock. Readback is only meaningful while ready is high
//////////////////////////////
`timescale 1ns/1ps

module panel_ctrl_top (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        data_in,
    input  logic              data_valid,
    output logic              ready,
    output logic              cmd_done,
    input  panel_pkg::row_t   rd_row,
    input  panel_pkg::col_t   rd_column,
    input  panel_pkg::pix_t   rd_pixel,
    output logic [7:0]        rd_data
);

    fb_write_if fb_bus ();

    control_cmd_dispatch i_dispatch (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .ready(ready),
        .cmd_done(cmd_done),
        .fb(fb_bus.writer)
    );

    framebuffer i_framebuffer (
        .clk(clk),
        .fb(fb_bus.memory),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

endmodule

/* hdl/framebuffer.sv */
//////////////////////////////
// Contents are not reset. Reads return one cycle after the address
//////////////////////////////
`timescale 1ns/1ps

module framebuffer (
    input  logic              clk,
    fb_write_if.memory        fb,
    input  panel_pkg::row_t   rd_row,
    input  panel_pkg::col_t   rd_column,
    input  panel_pkg::pix_t   rd_pixel,
    output logic [7:0]        rd_data
);

    logic [7:0] mem [panel_pkg::FB_BYTES];
    logic [panel_pkg::FB_ADDR_BITS-1:0] wr_addr;
    logic [panel_pkg::FB_ADDR_BITS-1:0] rd_addr;

    assign wr_addr = panel_pkg::fb_addr(fb.row, fb.column, fb.pixel);
    assign rd_addr = panel_pkg::fb_addr(rd_row, rd_column, rd_pixel);

    always_ff @(posedge clk) begin
        if (fb.write_enable) begin
            mem[wr_addr] <= fb.data;
        end
    end

    // A write in the same cycle is not forwarded to the registered read port
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* control/control_cmd_dispatch.sv */
//////////////////////////////
// Unknown opcodes are dropped. ready stays low from the last argument until cmd_done
//////////////////////////////
`timescale 1ns/1ps

module control_cmd_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       data_valid,
    output logic       ready,
    output logic       cmd_done,
    fb_write_if.writer fb
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARG,
        ST_BUSY
    } state_t;

    state_t state;
    logic [7:0] opcode;
    logic [panel_pkg::ARG_CNT_BITS-1:0] arg_count;
    logic [panel_pkg::ARG_CNT_BITS-1:0] arg_last;
    logic accept;
    logic rect_sel;
    logic panel_done;
    logic rect_done;

    fb_write_if panel_bus ();
    fb_write_if rect_bus ();

    assign ready = (state != ST_BUSY);
    assign accept = data_valid && ready;
    assign rect_sel = (opcode == panel_pkg::OP_FILL_RECT);
    assign arg_last = rect_sel ?
        (panel_pkg::ARG_CNT_BITS)'(panel_pkg::FILLRECT_ARG_BYTES - 1) :
        (panel_pkg::ARG_CNT_BITS)'(panel_pkg::FILLPANEL_ARG_BYTES - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            opcode <= 8'h00;
            arg_count <= '0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept && (data_in == panel_pkg::OP_FILL_PANEL ||
                                   data_in == panel_pkg::OP_FILL_RECT)) begin
                        opcode <= data_in;
                        arg_count <= '0;
                        state <= ST_ARG;
                    end
                end
                ST_ARG: begin
                    if (accept) begin
                        if (arg_count == arg_last) begin
                            state <= ST_BUSY;
                        end else begin
                            arg_count <= arg_count + 1'b1;
                        end
                    end
                end
                ST_BUSY: begin
                    if (panel_done || rect_done) begin
                        cmd_done <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    control_cmd_fillpanel i_fillpanel (
        .clk(clk),
        .reset(reset),
        .byte_in(data_in),
        .byte_valid(accept && state == ST_ARG && !rect_sel),
        .done(panel_done),
        .fb(panel_bus.writer)
    );

    control_cmd_fillrect i_fillrect (
        .clk(clk),
        .reset(reset),
        .byte_in(data_in),
        .byte_valid(accept && state == ST_ARG && rect_sel),
        .done(rect_done),
        .fb(rect_bus.writer)
    );

    // The command named by the last opcode owns the frame buffer port
    assign fb.row = rect_sel ? rect_bus.row : panel_bus.row;
    assign fb.column = rect_sel ? rect_bus.column : panel_bus.column;
    assign fb.pixel = rect_sel ? rect_bus.pixel : panel_bus.pixel;
    assign fb.data = rect_sel ? rect_bus.data : panel_bus.data;
    assign fb.write_enable = rect_sel ? rect_bus.write_enable : panel_bus.write_enable;

    // The host may only talk to us while no fill is writing
    a_ready_idle: assert property (@(posedge clk) disable iff (reset)
        ready |-> !fb.write_enable);

endmodule

/* control/control_cmd_fillrect.sv */
//////////////////////////////
// Arguments are x1, y1, width, height, then red, green, blue
//////////////////////////////
`timescale 1ns/1ps

module control_cmd_fillrect (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    output logic       done,
    fb_write_if.writer fb
);

    typedef enum logic [1:0] {
        ST_CAPTURE,
        ST_RUN,
        ST_FINISH
    } state_t;

    state_t state;
    logic [panel_pkg::ARG_CNT_BITS-1:0] byte_count;
    logic area_enable;
    logic area_done;
    logic [8*panel_pkg::FILLRECT_ARG_BYTES-1:0] args;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            byte_count <= '0;
            area_enable <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_CAPTURE: begin
                    if (byte_valid) begin
                        if (byte_count ==
                            (panel_pkg::ARG_CNT_BITS)'(panel_pkg::FILLRECT_ARG_BYTES - 1)) begin
                            byte_count <= '0;
                            area_enable <= 1'b1;
                            state <= ST_RUN;
                        end else begin
                            byte_count <= byte_count + 1'b1;
                        end
                    end
                end
                ST_RUN: begin
                    if (area_done) begin
                        area_enable <= 1'b0;
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    done <= 1'b1;
                    state <= ST_CAPTURE;
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_CAPTURE && byte_valid) begin
            args <= {args[8*panel_pkg::FILLRECT_ARG_BYTES-9:0], byte_in};
        end else if (state == ST_FINISH) begin
            args <= '0;
        end
    end

    //////////////////////////////
    // Argument layout after the last shift
    //////////////////////////////
    control_subcmd_fillarea i_fillarea (
        .clk(clk),
        .reset(reset),
        .enable(area_enable),
        .x1(args[55:48]),
        .y1(args[47:40]),
        .width(args[39:32]),
        .height(args[31:24]),
        .color(args[23:0]),
        .done(area_done),
        .fb(fb)
    );

endmodule

/* control/control_cmd_fillpanel.sv */
//////////////////////////////
// Expects exactly three colour bytes, red first
//////////////////////////////
`timescale 1ns/1ps

module control_cmd_fillpanel (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    output logic       done,
    fb_write_if.writer fb
);

    typedef enum logic [1:0] {
        ST_CAPTURE,
        ST_RUN,
        ST_FINISH
    } state_t;

    state_t state;
    logic [panel_pkg::ARG_CNT_BITS-1:0] byte_count;
    logic area_enable;
    logic area_done;
    panel_pkg::color_t color;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            byte_count <= '0;
            area_enable <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_CAPTURE: begin
                    if (byte_valid) begin
                        if (byte_count ==
                            (panel_pkg::ARG_CNT_BITS)'(panel_pkg::FILLPANEL_ARG_BYTES - 1)) begin
                            byte_count <= '0;
                            area_enable <= 1'b1;
                            state <= ST_RUN;
                        end else begin
                            byte_count <= byte_count + 1'b1;
                        end
                    end
                end
                ST_RUN: begin
                    if (area_done) begin
                        area_enable <= 1'b0;
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    done <= 1'b1;
                    state <= ST_CAPTURE;
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

    // Bytes shift in from the bottom so the first one ends up as red
    always_ff @(posedge clk) begin
        if (state == ST_CAPTURE && byte_valid) begin
            color <= {color[15:0], byte_in};
        end else if (state == ST_FINISH) begin
            color <= '0;
        end
    end

    control_subcmd_fillarea i_fillarea (
        .clk(clk),
        .reset(reset),
        .enable(area_enable),
        .x1(8'd0),
        .y1(8'd0),
        .width(8'(panel_pkg::PANEL_WIDTH)),
        .height(8'(panel_pkg::PANEL_HEIGHT)),
        .color(color),
        .done(area_done),
        .fb(fb)
    );

endmodule

/* control/control_subcmd_fillarea.sv */
//////////////////////////////
// Inputs must stay stable while enable is high. Off-panel bytes still cost a cycle
//////////////////////////////
`timescale 1ns/1ps

module control_subcmd_fillarea (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic [7:0]        x1,
    input  logic [7:0]        y1,
    input  logic [7:0]        width,
    input  logic [7:0]        height,
    input  panel_pkg::color_t color,
    output logic              done,
    fb_write_if.writer        fb
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_t;

    state_t state;
    logic [7:0] col_off;
    logic [7:0] row_off;
    panel_pkg::pix_t pix;
    logic [8:0] col_sum;
    logic [8:0] row_sum;
    logic in_panel;
    logic last_col;
    logic last_byte;

    assign col_sum = {1'b0, x1} + {1'b0, col_off};
    assign row_sum = {1'b0, y1} + {1'b0, row_off};
    assign in_panel = (col_sum < 9'(panel_pkg::PANEL_WIDTH)) &&
                      (row_sum < 9'(panel_pkg::PANEL_HEIGHT));
    assign last_col = (col_off == width - 8'd1);
    assign last_byte = last_col && (row_off == height - 8'd1) && (pix == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            col_off <= '0;
            row_off <= '0;
            pix <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (enable) begin
                        col_off <= '0;
                        row_off <= '0;
                        pix <= (panel_pkg::PIX_BITS)'(panel_pkg::BYTES_PER_PIXEL - 1);
                        // An empty area goes straight to done
                        state <= (width == 8'd0 || height == 8'd0) ? ST_DONE : ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (pix != '0) begin
                        pix <= pix - 1'b1;
                    end else begin
                        pix <= (panel_pkg::PIX_BITS)'(panel_pkg::BYTES_PER_PIXEL - 1);
                        if (last_col) begin
                            col_off <= '0;
                            row_off <= row_off + 8'd1;
                        end else begin
                            col_off <= col_off + 8'd1;
                        end
                        if (last_byte) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    if (!enable) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign done = (state == ST_DONE);

    assign fb.row = row_sum[panel_pkg::ROW_BITS-1:0];
    assign fb.column = col_sum[panel_pkg::COL_BITS-1:0];
    assign fb.pixel = pix;
    assign fb.data = color[8*pix +: 8];
    // Clipping happens here and the walk itself is never shortened
    assign fb.write_enable = (state == ST_RUN) && in_panel;

    // Writes stay inside the requested rectangle, and only while the owning
    // command still holds enable
    a_write_clipped: assert property (@(posedge clk) disable iff (reset)
        fb.write_enable |-> enable && (col_off < width) && (row_off < height));

endmodule

/* common/fb_write_if.sv */
//////////////////////////////
// One byte write per cycle, qualified by write_enable
//////////////////////////////
`timescale 1ns/1ps

interface fb_write_if;

    panel_pkg::row_t row;
    panel_pkg::col_t column;
    panel_pkg::pix_t pixel;
    logic [7:0] data;
    logic write_enable;

    modport writer (
        output row, column, pixel, data, write_enable
    );

    modport memory (
        input row, column, pixel, data, write_enable
    );

endinterface

/* common/panel_pkg.sv */
//////////////////////////////
// Sizes are fixed at 64x32 with 3 bytes per pixel. Pixel select 3 has no storage
//////////////////////////////

package panel_pkg;

    localparam int PANEL_WIDTH = 64;
    localparam int PANEL_HEIGHT = 32;
    localparam int BYTES_PER_PIXEL = 3;

    localparam int COL_BITS = 6;
    localparam int ROW_BITS = 5;
    localparam int PIX_BITS = 2;

    localparam int FB_BYTES = PANEL_WIDTH * PANEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int FB_ADDR_BITS = 13;

    typedef logic [COL_BITS-1:0] col_t;
    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [PIX_BITS-1:0] pix_t;

    // Red in the top byte, blue in the bottom byte
    typedef logic [8*BYTES_PER_PIXEL-1:0] color_t;

    localparam logic [7:0] OP_FILL_PANEL = 8'h01;
    localparam logic [7:0] OP_FILL_RECT = 8'h02;

    localparam int FILLPANEL_ARG_BYTES = 3;
    localparam int FILLRECT_ARG_BYTES = 7;
    localparam int ARG_CNT_BITS = 3;

    // Linear byte address with pixels stored row after row
    function automatic logic [FB_ADDR_BITS-1:0] fb_addr(row_t row, col_t column, pix_t pixel);
        return FB_ADDR_BITS'({row, column}) * FB_ADDR_BITS'(BYTES_PER_PIXEL)
               + FB_ADDR_BITS'(pixel);
    endfunction

endpackage
